// ==== verilog/rxbd_pkg.sv ====
//--------------------
// shared constants of the rx BD command path
// BD word with raw and field views
//--------------------

package rxbd_pkg;

    // ddr channel select comes from the top two address bits
    localparam int CHAN_NUM = 4;
    localparam int CHAN_W = 2;

    localparam int ADDR_W = 36;
    localparam int LEN_W = 32;

    // 4 KB pages
    localparam int PAGE_BITS = 12;

    localparam int BD_W = 128;

    // queued command layout, msb first: len, addr, last
    localparam int CMD_W = LEN_W + ADDR_W + 1;

    //--------------------
    // BD word
    //--------------------
    // the input queue only stores the raw word
    // the splitter reads length and destination from the field view
    typedef union packed {
        logic [BD_W-1:0] raw;
        struct packed {
            logic [BD_W-LEN_W-ADDR_W-1:0] rsv;
            logic [LEN_W-1:0]             len;
            logic [ADDR_W-1:0]            addr;
        } fld;
    } bd_word_t;

endpackage

// ==== verilog/sync_fifo.sv ====
//--------------------
// single-clock FIFO, first-word-fall-through
// register array with fill count
//--------------------

`timescale 1ns/10ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                       clk_sys,
    input  logic                       rst,
    input  logic                       wr,
    input  logic [WIDTH-1:0]           wdata,
    input  logic                       rd,
    output logic [WIDTH-1:0]           rdata,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             wr_en;
    logic             rd_en;
    logic [CNT_W-1:0] count_nxt;

    // pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign wr_en = wr & ~full;
    assign rd_en = rd & ~empty;
    assign empty = (count == '0);
    // head entry is always visible
    assign rdata = mem[rd_ptr];

    always_comb begin
        count_nxt = count;
        if (wr_en && !rd_en) begin
            count_nxt = count + CNT_W'(1);
        end else if (rd_en && !wr_en) begin
            count_nxt = count - CNT_W'(1);
        end
    end

    // full sits high in reset so nothing is written before the first edge
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b1;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count <= count_nxt;
            full  <= (count_nxt == CNT_W'(DEPTH));
        end
    end

    always_ff @(posedge clk_sys) begin
        if (wr_en) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

// ==== verilog/bd_splitter.sv ====
//--------------------
// BD splitter
// pops BDs, cuts them into 4 KB read commands
// routes commands by channel, logs channel order
//--------------------

`timescale 1ns/10ps

module bd_splitter
    import rxbd_pkg::*;
(
    input  logic                clk_sys,
    input  logic                rst,
    input  logic                bd_empty,
    input  bd_word_t            bd_rdata,
    output logic                bd_pop,
    input  logic [CHAN_NUM-1:0] chan_afull,
    input  logic                seq_afull,
    output logic [CHAN_NUM-1:0] cmd_wr,
    output logic [LEN_W-1:0]    cmd_len,
    output logic [ADDR_W-1:0]   cmd_addr,
    output logic                cmd_last,
    output logic                seq_wr,
    output logic [CHAN_W-1:0]   seq_chan,
    output logic                len_err
);

    localparam int SEG_W = LEN_W - PAGE_BITS + 1;
    localparam int PAGE_W = ADDR_W - CHAN_W - PAGE_BITS;
    localparam logic [LEN_W-1:0] SEG_BYTES = LEN_W'(1) << PAGE_BITS;

    logic                       stall_s1;
    logic                       stall_s2;
    logic                       busy;
    logic                       first_seg;
    logic [SEG_W-1:0]           seg_left;
    logic [PAGE_BITS:0]         last_len;
    logic [ADDR_W-1:0]          cur_addr;
    logic [LEN_W-PAGE_BITS-1:0] bd_pages;
    logic [PAGE_BITS-1:0]       bd_rem;
    logic [SEG_W-1:0]           bd_segs;
    logic [PAGE_BITS:0]         bd_last_len;
    logic                       issue;
    logic                       finish;
    logic [CHAN_W-1:0]          chan;

    //--------------------
    // decode of the head BD
    //--------------------
    assign bd_pages = bd_rdata.fld.len[LEN_W-1:PAGE_BITS];
    assign bd_rem   = bd_rdata.fld.len[PAGE_BITS-1:0];

    // segment count and size of the final segment
    always_comb begin
        if (bd_rem != '0) begin
            bd_segs     = {1'b0, bd_pages} + SEG_W'(1);
            bd_last_len = {1'b0, bd_rem};
        end else if (bd_pages != '0) begin
            bd_segs     = {1'b0, bd_pages};
            bd_last_len = SEG_BYTES[PAGE_BITS:0];
        end else begin
            // zero length still yields one empty command
            bd_segs     = SEG_W'(1);
            bd_last_len = '0;
        end
    end

    //--------------------
    // stall and pop
    //--------------------
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            stall_s1 <= 1'b0;
            stall_s2 <= 1'b0;
        end else begin
            stall_s1 <= (|chan_afull) | seq_afull;
            stall_s2 <= stall_s1;
        end
    end

    // first segment goes out regardless of stall, the rest wait
    assign issue  = busy & (first_seg | ~stall_s2);
    assign finish = issue & (seg_left == SEG_W'(1));

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            bd_pop  <= 1'b0;
            seq_wr  <= 1'b0;
            len_err <= 1'b0;
        end else begin
            // a split ending this cycle does not block the next pop
            bd_pop  <= ~bd_empty & ~(busy & ~finish) & ~stall_s2 & ~bd_pop;
            seq_wr  <= bd_pop;
            len_err <= bd_pop & (bd_rdata.fld.len == '0);
        end
    end

    //--------------------
    // segment issue
    //--------------------
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            first_seg <= 1'b0;
            seg_left  <= '0;
        end else if (bd_pop) begin
            busy      <= 1'b1;
            first_seg <= 1'b1;
            seg_left  <= bd_segs;
        end else if (issue) begin
            first_seg <= 1'b0;
            seg_left  <= seg_left - SEG_W'(1);
            if (finish) begin
                busy <= 1'b0;
            end
        end
    end

    // page step carries through bits 33..12, channel bits stay put
    always_ff @(posedge clk_sys) begin
        if (bd_pop) begin
            cur_addr <= bd_rdata.fld.addr;
            last_len <= bd_last_len;
        end else if (issue) begin
            cur_addr[ADDR_W-CHAN_W-1:PAGE_BITS] <=
                cur_addr[ADDR_W-CHAN_W-1:PAGE_BITS] + PAGE_W'(1);
        end
    end

    assign chan     = cur_addr[ADDR_W-1 -: CHAN_W];
    assign cmd_last = (seg_left == SEG_W'(1));
    assign cmd_len  = cmd_last ? LEN_W'(last_len) : SEG_BYTES;
    assign cmd_addr = cur_addr;
    assign cmd_wr   = issue ? (CHAN_NUM'(1) << chan) : '0;
    assign seq_chan = chan;

endmodule

// ==== verilog/chan_queue.sv ====
//--------------------
// per-channel command queue
// outstanding byte budget and almost-full
//--------------------

`timescale 1ns/10ps

module chan_queue
    import rxbd_pkg::*;
#(
    parameter int CMD_DEPTH = 16,
    parameter int BYTE_BUDGET = 16384
) (
    input  logic             clk_sys,
    input  logic             rst,
    input  logic             wr,
    input  logic [CMD_W-1:0] wdata,
    input  logic             rd,
    output logic [CMD_W-1:0] rdata,
    output logic             empty,
    output logic             afull
);

    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    logic             full;
    logic [CNT_W-1:0] count;
    logic             wr_ok;
    logic             rd_ok;
    logic [LEN_W-1:0] wr_len;
    logic [LEN_W-1:0] rd_len;
    logic [LEN_W-1:0] bytes_q;

    sync_fifo #(
        .WIDTH (CMD_W),
        .DEPTH (CMD_DEPTH)
    ) cmd_fifo (
        .clk_sys (clk_sys),
        .rst     (rst),
        .wr      (wr),
        .wdata   (wdata),
        .rd      (rd),
        .rdata   (rdata),
        .empty   (empty),
        .full    (full),
        .count   (count)
    );

    // only accepted transfers move the byte count
    assign wr_ok  = wr & ~full;
    assign rd_ok  = rd & ~empty;
    assign wr_len = wr_ok ? wdata[CMD_W-1 -: LEN_W] : '0;
    assign rd_len = rd_ok ? rdata[CMD_W-1 -: LEN_W] : '0;

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            bytes_q <= '0;
        end else begin
            bytes_q <= bytes_q + wr_len - rd_len;
        end
    end

    // four spare entries absorb the splitter's two-stage stall
    assign afull = (bytes_q >= LEN_W'(BYTE_BUDGET))
                 | (count > CNT_W'(CMD_DEPTH - 4));

endmodule

// ==== verilog/rcmd_merge.sv ====
//--------------------
// command merge
// drains channel queues in BD order
// one output register, gated by rcmd_full
//--------------------

`timescale 1ns/10ps

module rcmd_merge
    import rxbd_pkg::*;
(
    input  logic                           clk_sys,
    input  logic                           rst,
    // channel-order queue
    input  logic                           seq_empty,
    input  logic [CHAN_W-1:0]              seq_rdata,
    output logic                           seq_rd,
    // channel command queues
    input  logic [CHAN_NUM-1:0]            chan_empty,
    input  logic [CHAN_NUM-1:0][CMD_W-1:0] chan_rdata,
    output logic [CHAN_NUM-1:0]            chan_rd,
    // command output
    input  logic                           rcmd_full,
    output logic                           rcmd_wen,
    output logic [LEN_W-1:0]               rcmd_len,
    output logic [ADDR_W-1:0]              rcmd_addr,
    output logic [CHAN_W-1:0]              rcmd_chan,
    output logic                           rcmd_last
);

    logic [CMD_W-1:0] head;
    logic             head_last;
    logic             out_valid;
    logic             load;

    //--------------------
    // head selection
    //--------------------
    // the order queue names the channel that owns the oldest BD
    assign head      = chan_rdata[seq_rdata];
    assign head_last = head[0];

    // the output register takes a new command when it is free or
    // being written out in this cycle
    assign load = ~seq_empty
                & ~chan_empty[seq_rdata]
                & (~out_valid | ~rcmd_full);

    assign chan_rd = load ? (CHAN_NUM'(1) << seq_rdata) : '0;

    // move to the next BD once its last segment is taken
    assign seq_rd = load & head_last;

    //--------------------
    // output register
    //--------------------
    assign rcmd_wen = out_valid & ~rcmd_full;

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (rcmd_wen) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (load) begin
            rcmd_len  <= head[CMD_W-1 -: LEN_W];
            rcmd_addr <= head[ADDR_W:1];
            rcmd_chan <= seq_rdata;
            rcmd_last <= head_last;
        end
    end

endmodule

// ==== verilog/mmu_rx_bd.sv ====
//--------------------
// rx BD to DDR read command top level
// BD queue, splitter, channel queues,
// channel-order queue and merge
//--------------------

`timescale 1ns/10ps

module mmu_rx_bd
    import rxbd_pkg::*;
#(
    parameter int BD_DEPTH = 8,
    parameter int CMD_DEPTH = 16,
    parameter int SEQ_DEPTH = 16,
    parameter int BYTE_BUDGET = 16384
) (
    input  logic              clk_sys,
    input  logic              rst,
    input  logic              bd_valid,
    input  bd_word_t          bd_word,
    output logic              bd_ready,
    input  logic              rcmd_full,
    output logic              rcmd_wen,
    output logic [LEN_W-1:0]  rcmd_len,
    output logic [ADDR_W-1:0] rcmd_addr,
    output logic [CHAN_W-1:0] rcmd_chan,
    output logic              rcmd_last,
    output logic              len_err,
    output logic              bd_pop
);

    localparam int SEQ_CNT_W = $clog2(SEQ_DEPTH + 1);

    logic                           bd_full;
    logic                           bd_empty;
    bd_word_t                       bd_rdata;
    logic [CHAN_NUM-1:0]            cmd_wr;
    logic [LEN_W-1:0]               cmd_len;
    logic [ADDR_W-1:0]              cmd_addr;
    logic                           cmd_last;
    logic [CMD_W-1:0]               cmd_wdata;
    logic [CHAN_NUM-1:0]            chan_afull;
    logic [CHAN_NUM-1:0]            chan_empty;
    logic [CHAN_NUM-1:0][CMD_W-1:0] chan_rdata;
    logic [CHAN_NUM-1:0]            chan_rd;
    logic                           seq_wr;
    logic [CHAN_W-1:0]              seq_chan;
    logic                           seq_afull;
    logic                           seq_empty;
    logic [CHAN_W-1:0]              seq_rdata;
    logic                           seq_rd;
    logic [SEQ_CNT_W-1:0]           seq_count;

    assign bd_ready  = ~bd_full;
    assign cmd_wdata = {cmd_len, cmd_addr, cmd_last};
    assign seq_afull = (seq_count > SEQ_CNT_W'(SEQ_DEPTH - 4));

    sync_fifo #(.WIDTH(BD_W), .DEPTH(BD_DEPTH)) bd_fifo (
        .clk_sys (clk_sys), .rst (rst),
        .wr (bd_valid), .wdata (bd_word.raw),
        .rd (bd_pop), .rdata (bd_rdata),
        .empty (bd_empty), .full (bd_full), .count ()
    );

    bd_splitter splitter (
        .clk_sys (clk_sys), .rst (rst),
        .bd_empty (bd_empty), .bd_rdata (bd_rdata), .bd_pop (bd_pop),
        .chan_afull (chan_afull), .seq_afull (seq_afull),
        .cmd_wr (cmd_wr), .cmd_len (cmd_len), .cmd_addr (cmd_addr), .cmd_last (cmd_last),
        .seq_wr (seq_wr), .seq_chan (seq_chan), .len_err (len_err)
    );

    // one command queue per ddr channel
    for (genvar g = 0; g < CHAN_NUM; g++) begin : gen_chan
        chan_queue #(.CMD_DEPTH(CMD_DEPTH), .BYTE_BUDGET(BYTE_BUDGET)) chan_q (
            .clk_sys (clk_sys), .rst (rst),
            .wr (cmd_wr[g]), .wdata (cmd_wdata),
            .rd (chan_rd[g]), .rdata (chan_rdata[g]),
            .empty (chan_empty[g]), .afull (chan_afull[g])
        );
    end

    sync_fifo #(.WIDTH(CHAN_W), .DEPTH(SEQ_DEPTH)) seq_fifo (
        .clk_sys (clk_sys), .rst (rst),
        .wr (seq_wr), .wdata (seq_chan),
        .rd (seq_rd), .rdata (seq_rdata),
        .empty (seq_empty), .full (), .count (seq_count)
    );

    rcmd_merge merge (
        .clk_sys (clk_sys), .rst (rst),
        .seq_empty (seq_empty), .seq_rdata (seq_rdata), .seq_rd (seq_rd),
        .chan_empty (chan_empty), .chan_rdata (chan_rdata), .chan_rd (chan_rd),
        .rcmd_full (rcmd_full), .rcmd_wen (rcmd_wen), .rcmd_len (rcmd_len),
        .rcmd_addr (rcmd_addr), .rcmd_chan (rcmd_chan), .rcmd_last (rcmd_last)
    );

endmodule

// ==== test/mmu_rx_bd_properties.sv ====
//--------------------
// concurrent assertions on the rx BD top level
// output handshake, splitter strobes, reset state
//--------------------

`timescale 1ns/10ps

module mmu_rx_bd_properties
    import rxbd_pkg::*;
(
    input logic                clk_sys,
    input logic                rst,
    input logic                bd_pop,
    input logic [CHAN_NUM-1:0] cmd_wr,
    input logic                rcmd_full,
    input logic                rcmd_wen,
    input logic                len_err
);

    // no write strobe while downstream is full
    wen_not_full: assert property (@(posedge clk_sys) disable iff (rst)
        !(rcmd_wen && rcmd_full))
        else $error("rcmd_wen high while rcmd_full is high");

    // a segment goes to one channel at most
    cmd_wr_onehot: assert property (@(posedge clk_sys) disable iff (rst)
        $onehot0(cmd_wr))
        else $error("cmd_wr has more than one channel strobe");

    // pops are spaced by at least one idle cycle
    pop_spaced: assert property (@(posedge clk_sys) disable iff (rst)
        bd_pop |=> !bd_pop)
        else $error("bd_pop high in two consecutive cycles");

    // first cycle out of reset is quiet
    idle_after_reset: assert property (@(posedge clk_sys)
        $fell(rst) |-> (!rcmd_wen && !len_err && !bd_pop && cmd_wr == '0))
        else $error("outputs active in the first cycle after reset");

endmodule

// ==== test/tb_mmu_rx_bd.sv ====
//--------------------
// testbench for the rx BD command path
// file-driven BDs, expected-command model,
// output monitor and random back-pressure
//--------------------

`timescale 1ns/10ps

module tb_mmu_rx_bd
    import rxbd_pkg::*;
();

    localparam int PERIOD        = 20;
    localparam int DRIVE_DLY     = 2;
    localparam int READY_TIMEOUT = 2000;
    localparam int DRAIN_TIMEOUT = 5000;

    logic              clk_sys;
    logic              rst;
    logic              bd_valid;
    bd_word_t          bd_word;
    logic              bd_ready;
    logic              rcmd_full;
    logic              rcmd_wen;
    logic [LEN_W-1:0]  rcmd_len;
    logic [ADDR_W-1:0] rcmd_addr;
    logic [CHAN_W-1:0] rcmd_chan;
    logic              rcmd_last;
    logic              len_err;
    logic              bd_pop;

    integer            seed;
    bit                full_random = 1'b0;
    int                len_err_seen = 0;
    int                zero_bds = 0;
    int                pop_seen = 0;
    int                bds_sent = 0;

    // stimulus as read from the file
    logic [LEN_W-1:0]  stim_len[$];
    logic [ADDR_W-1:0] stim_addr[$];
    int                stim_cnt[$];

    // expected commands in output order
    logic [LEN_W-1:0]  exp_len[$];
    logic [ADDR_W-1:0] exp_addr[$];
    bit                exp_last[$];

    mmu_rx_bd #(
        .BD_DEPTH    (8),
        .CMD_DEPTH   (16),
        .SEQ_DEPTH   (16),
        .BYTE_BUDGET (16384)
    ) dut0 (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .bd_valid  (bd_valid),
        .bd_word   (bd_word),
        .bd_ready  (bd_ready),
        .rcmd_full (rcmd_full),
        .rcmd_wen  (rcmd_wen),
        .rcmd_len  (rcmd_len),
        .rcmd_addr (rcmd_addr),
        .rcmd_chan (rcmd_chan),
        .rcmd_last (rcmd_last),
        .len_err   (len_err),
        .bd_pop    (bd_pop)
    );

    bind mmu_rx_bd mmu_rx_bd_properties props0 (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .bd_pop    (bd_pop),
        .cmd_wr    (cmd_wr),
        .rcmd_full (rcmd_full),
        .rcmd_wen  (rcmd_wen),
        .len_err   (len_err)
    );

    //--------------------
    // clock and back-pressure
    //--------------------
    initial begin
        clk_sys = 1'b0;
        forever #(PERIOD / 2) clk_sys = ~clk_sys;
    end

    // downstream full about five cycles in eight during phase two
    initial begin
        seed = 65;
        rcmd_full = 1'b0;
        forever begin
            @(posedge clk_sys);
            #DRIVE_DLY;
            if (full_random) begin
                rcmd_full = (($random(seed) & 7) < 5);
            end else begin
                rcmd_full = 1'b0;
            end
        end
    end

    //--------------------
    // checks
    //--------------------
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            stop_run($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, want));
        end
    endtask

    // split rule: 4 KB segments at consecutive pages, remainder last
    task automatic push_expected(input logic [LEN_W-1:0] len, input logic [ADDR_W-1:0] addr,
                                 output int n);
        logic [19:0] pages;
        logic [11:0] rem;
        logic [12:0] last_len;
        logic [21:0] page;
        int          k;
        pages = len[LEN_W-1:PAGE_BITS];
        rem   = len[PAGE_BITS-1:0];
        if (rem != 12'h0) begin
            n        = int'(pages) + 1;
            last_len = {1'b0, rem};
        end else if (pages != 20'h0) begin
            n        = int'(pages);
            last_len = 13'h1000;
        end else begin
            n        = 1;
            last_len = 13'h0;
        end
        for (k = 0; k < n; k++) begin
            // page field wraps inside bits 33..12
            page = addr[33:12] + 22'(k);
            exp_addr.push_back({addr[35:34], page, addr[11:0]});
            exp_len.push_back((k == n - 1) ? {19'h0, last_len} : 32'h1000);
            exp_last.push_back(k == n - 1);
        end
    endtask

    task automatic check_command();
        logic [LEN_W-1:0]  want_len;
        logic [ADDR_W-1:0] want_addr;
        bit                want_last;
        if (exp_len.size() == 0) begin
            stop_run("a command was written while none was expected");
        end else begin
            want_len  = exp_len.pop_front();
            want_addr = exp_addr.pop_front();
            want_last = exp_last.pop_front();
            check_value("rcmd_len", 64'(rcmd_len), 64'(want_len));
            check_value("rcmd_addr", 64'(rcmd_addr), 64'(want_addr));
            check_value("rcmd_chan", 64'(rcmd_chan), 64'(want_addr[ADDR_W-1 -: CHAN_W]));
            check_value("rcmd_last", 64'(rcmd_last), 64'(want_last));
            check_value("rcmd_full", 64'(rcmd_full), 64'(0));
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk_sys) begin
        if (!rst) begin
            if (rcmd_wen) begin
                check_command();
            end
            if (len_err) begin
                len_err_seen++;
            end
            if (bd_pop) begin
                pop_seen++;
            end
        end
    end

    //--------------------
    // stimulus
    //--------------------
    task automatic load_stim();
        int                fd;
        string             line;
        logic [LEN_W-1:0]  len;
        logic [ADDR_W-1:0] addr;
        int                cnt;
        fd = $fopen("test/bd_stim.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open the stimulus file test/bd_stim.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line.substr(0, 0) != "#") begin
                if ($sscanf(line, "%h %h %d", len, addr, cnt) == 3) begin
                    stim_len.push_back(len);
                    stim_addr.push_back(addr);
                    stim_cnt.push_back(cnt);
                end
            end
        end
        $fclose(fd);
        if (stim_len.size() == 0) begin
            stop_run("the stimulus file holds no BDs");
        end
    endtask

    // called just after a rising edge, returns at the same point
    task automatic send_bd(input logic [LEN_W-1:0] len, input logic [ADDR_W-1:0] addr);
        bd_word_t word;
        int       waited;
        bit       accepted;
        word.raw      = '0;
        word.fld.len  = len;
        word.fld.addr = addr;
        bd_word  = word;
        bd_valid = 1'b1;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk_sys);
            if (bd_ready) begin
                accepted = 1'b1;
            end else begin
                waited++;
                if (waited > READY_TIMEOUT) begin
                    stop_run("bd_ready stayed low too long while a BD was offered");
                end
            end
        end
        @(posedge clk_sys);
        #DRIVE_DLY;
        bd_valid = 1'b0;
    endtask

    task automatic run_stim();
        int i;
        int n;
        for (i = 0; i < stim_len.size(); i++) begin
            push_expected(stim_len[i], stim_addr[i], n);
            check_value("cmd_count", 64'(n), 64'(stim_cnt[i]));
            if (stim_len[i] == '0) begin
                zero_bds++;
            end
            send_bd(stim_len[i], stim_addr[i]);
            bds_sent++;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_len.size() != 0) begin
            @(negedge clk_sys);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                stop_run("expected commands did not all arrive in time");
            end
        end
        @(posedge clk_sys);
        #DRIVE_DLY;
    endtask

    task automatic wait_ready_after_reset();
        int waited;
        waited = 0;
        while (!bd_ready) begin
            @(negedge clk_sys);
            waited++;
            if (waited > 20) begin
                stop_run("bd_ready did not rise after reset");
            end
        end
        @(posedge clk_sys);
        #DRIVE_DLY;
    endtask

    //--------------------
    // main sequence
    //--------------------
    initial begin
        rst      = 1'b1;
        bd_valid = 1'b0;
        bd_word  = '0;
        load_stim();
        repeat (4) begin
            @(posedge clk_sys);
            #DRIVE_DLY;
            check_value("bd_ready", 64'(bd_ready), 64'(0));
            check_value("rcmd_wen", 64'(rcmd_wen), 64'(0));
            check_value("len_err", 64'(len_err), 64'(0));
        end
        rst = 1'b0;
        wait_ready_after_reset();

        // phase one, downstream always ready
        run_stim();
        wait_drain();
        check_value("len_err_count", 64'(len_err_seen), 64'(zero_bds));
        check_value("bd_pop_count", 64'(pop_seen), 64'(bds_sent));

        // phase two, same BDs under random rcmd_full
        full_random = 1'b1;
        run_stim();
        wait_drain();
        full_random = 1'b0;
        check_value("len_err_count", 64'(len_err_seen), 64'(zero_bds));
        check_value("bd_pop_count", 64'(pop_seen), 64'(bds_sent));

        // quiet tail catches stray commands
        repeat (20) @(posedge clk_sys);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/rxbd_pkg.sv
verilog/sync_fifo.sv
verilog/bd_splitter.sv
verilog/chan_queue.sv
verilog/rcmd_merge.sv
verilog/mmu_rx_bd.sv
test/mmu_rx_bd_properties.sv
test/tb_mmu_rx_bd.sv

// ==== Makefile ====
# Verilator build and run of the rx BD command path testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_mmu_rx_bd
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
JOBS      ?= 4

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS JOBS"

# the simulator's exit status is the test result
test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== test/bd_stim.txt ====
# columns: length (hex bytes)  destination address (hex, 36 bits)  expected commands (decimal)
# address bits 35..34 select the ddr channel
00000040 000001000 1
00000200 400002000 1
00000fff 800003000 1
00001000 c00004000 1
00001001 000010000 2
00002000 400020000 2
00003064 800030000 4
00000000 c00040000 1
00004000 000050000 4
00001800 ffffff800 2
00000123 400060abc 1
00002500 800070100 3
00000010 c00080010 1
00000000 000090000 1
0000a000 4000a0000 10
00000800 8000b0000 1
00005555 c000c0555 6
00000004 0000d0000 1
00001000 4000e0000 1
00003000 8000f0000 3
00000001 c00100fff 1
